// File: rtl/ppu_pkg.sv
// ppu register addresses, line timing constants, vram bases, mode and fetch enums, bus structs
`default_nettype none

package ppu_pkg;

    localparam logic [15:0] ADDR_LCDC = 16'hFF40;
    localparam logic [15:0] ADDR_STAT = 16'hFF41;
    localparam logic [15:0] ADDR_SCY  = 16'hFF42;
    localparam logic [15:0] ADDR_SCX  = 16'hFF43;
    localparam logic [15:0] ADDR_LY   = 16'hFF44;  // read only
    localparam logic [15:0] ADDR_LYC  = 16'hFF45;

    localparam int DOTS_PER_LINE   = 456;
    localparam int SCAN_DOTS       = 80;
    localparam int VISIBLE_LINES   = 144;
    localparam int LINES_PER_FRAME = 154;
    localparam int PIXELS_PER_LINE = 160;

    localparam logic [15:0] TILE_BASE_UNSIGNED = 16'h8000;
    localparam logic [15:0] TILE_BASE_SIGNED   = 16'h9000;  // tile 0 of the signed set
    localparam logic [15:0] MAP_BASE_LO        = 16'h9800;
    localparam logic [15:0] MAP_BASE_HI        = 16'h9C00;

    // codes match the stat mode field
    typedef enum logic [1:0] {
        h_blank  = 2'd0,
        v_blank  = 2'd1,
        oam_scan = 2'd2,
        draw     = 2'd3
    } ppu_mode_e;

    typedef enum logic [2:0] {
        fetch_idle,
        fetch_map,
        fetch_lo,
        fetch_hi,
        fetch_hold
    } fetch_state_e;

    typedef struct packed {
        logic [15:0] addr;
        logic        wr;
        logic        rd;
        logic [7:0]  wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic       lcd_on;         // lcdc[7]
        logic       bg_on;          // lcdc[0]
        logic       map_hi;         // lcdc[3]
        logic       tile_unsigned;  // lcdc[4]
        logic [7:0] scy;
        logic [7:0] scx;
    } ppu_cfg_t;

    typedef struct packed {
        ppu_mode_e  mode;
        logic [7:0] ly;
        logic [8:0] dot;
    } line_pos_t;

    typedef struct packed {
        logic [7:0] lo;
        logic [7:0] hi;
    } tile_row_t;

endpackage

`default_nettype wire

// File: rtl/ppu_regs.sv
// cpu register file with read mux, stat flags and interrupt levels
`timescale 1ns/1ps
`default_nettype none

module ppu_regs (
    input  logic                clk,
    input  logic                rst,
    input  ppu_pkg::cpu_bus_t   bus,
    input  ppu_pkg::line_pos_t  pos,
    output logic [7:0]          rdata,
    output ppu_pkg::ppu_cfg_t   cfg,
    output logic                irq_vblank,
    output logic                irq_stat
);
    import ppu_pkg::*;

    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [3:0] stat_en;   // stat bits 6..3
    logic       coinc;
    logic [7:0] stat_val;

    assign coinc    = (pos.ly == lyc);
    assign stat_val = {1'b1, stat_en, coinc, pos.mode};  // bit 7 always reads 1

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= 8'd0;
            scy     <= 8'd0;
            scx     <= 8'd0;
            lyc     <= 8'd0;
            stat_en <= 4'd0;
        end else if (bus.wr) begin
            case (bus.addr)
                ADDR_LCDC: lcdc    <= bus.wdata;
                ADDR_STAT: stat_en <= bus.wdata[6:3];  // mode and coincidence are read only
                ADDR_SCY:  scy     <= bus.wdata;
                ADDR_SCX:  scx     <= bus.wdata;
                ADDR_LYC:  lyc     <= bus.wdata;
                default:   ;                           // ly and unmapped ignore writes
            endcase
        end
    end

    always_comb begin
        rdata = 8'hFF;
        if (bus.rd) begin
            case (bus.addr)
                ADDR_LCDC: rdata = lcdc;
                ADDR_STAT: rdata = stat_val;
                ADDR_SCY:  rdata = scy;
                ADDR_SCX:  rdata = scx;
                ADDR_LY:   rdata = pos.ly;
                ADDR_LYC:  rdata = lyc;
                default:   rdata = 8'hFF;
            endcase
        end
    end

    always_comb begin
        cfg.lcd_on        = lcdc[7];
        cfg.bg_on         = lcdc[0];
        cfg.map_hi        = lcdc[3];
        cfg.tile_unsigned = lcdc[4];
        cfg.scy           = scy;
        cfg.scx           = scx;
    end

    assign irq_vblank = (pos.mode == v_blank);

    // any enabled stat source holds the line high
    assign irq_stat = (coinc && stat_en[3])
                   || (pos.mode == h_blank  && stat_en[0])
                   || (pos.mode == v_blank  && stat_en[1])
                   || (pos.mode == oam_scan && stat_en[2]);

endmodule

`default_nettype wire

// File: rtl/line_timer.sv
// dot counter, ly counter and scan/draw/h-blank/v-blank mode sequencer
`timescale 1ns/1ps
`default_nettype none

module line_timer (
    input  logic                clk,
    input  logic                rst,
    input  ppu_pkg::ppu_cfg_t   cfg,
    input  logic                line_done,
    output ppu_pkg::line_pos_t  pos
);
    import ppu_pkg::*;

    logic [8:0] dot;
    logic [7:0] ly;
    logic       in_draw;   // set at dot 80 of a visible line, cleared by line_done
    ppu_mode_e  mode;
    logic       line_end;

    assign line_end = (dot == 9'(DOTS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst || !cfg.lcd_on) begin
            dot     <= 9'd0;   // display off parks at line 0, dot 0
            ly      <= 8'd0;
            in_draw <= 1'b0;
        end else begin
            if (line_end) begin
                dot <= 9'd0;
                if (ly == 8'(LINES_PER_FRAME - 1)) begin
                    ly <= 8'd0;
                end else begin
                    ly <= ly + 8'd1;
                end
            end else begin
                dot <= dot + 9'd1;
            end

            if (dot == 9'(SCAN_DOTS - 1) && ly < 8'(VISIBLE_LINES)) begin
                in_draw <= 1'b1;
            end else if (line_done || line_end) begin
                in_draw <= 1'b0;
            end
        end
    end

    always_comb begin
        if (ly >= 8'(VISIBLE_LINES)) begin
            mode = v_blank;
        end else if (dot < 9'(SCAN_DOTS)) begin
            mode = oam_scan;   // idle scan window without sprites
        end else if (in_draw) begin
            mode = draw;
        end else begin
            mode = h_blank;
        end
    end

    always_comb begin
        pos.mode = mode;
        pos.ly   = ly;
        pos.dot  = dot;
    end

endmodule

`default_nettype wire

// File: rtl/bg_fetcher.sv
// background fetch FSM reading tile map entries and tile row bytes from vram
`timescale 1ns/1ps
`default_nettype none

module bg_fetcher #(
    parameter int VRAM_LATENCY = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  ppu_pkg::ppu_cfg_t   cfg,
    input  ppu_pkg::line_pos_t  pos,
    input  logic                row_free,
    input  logic [7:0]          vram_data,
    output logic                vram_rd,
    output logic [15:0]         vram_addr,
    output ppu_pkg::tile_row_t  row,
    output logic                row_valid
);
    import ppu_pkg::*;

    localparam int CW    = (VRAM_LATENCY < 1) ? 1 : $clog2(VRAM_LATENCY + 1);
    localparam int TILES = PIXELS_PER_LINE / 8;

    fetch_state_e  state;
    logic [CW-1:0] lat_cnt;
    logic [4:0]    tile_col;   // tiles presented this line
    logic [7:0]    lo_q;
    logic [7:0]    hi_q;
    logic [7:0]    bg_y;
    logic [4:0]    map_col;
    logic [15:0]   map_addr;
    logic [15:0]   tile_off;
    logic [15:0]   tile_addr;
    logic          data_ok;

    assign bg_y     = pos.ly + cfg.scy;             // wraps at 256
    assign map_col  = tile_col + cfg.scx[7:3];      // coarse scroll wrapping at 32
    assign map_addr = (cfg.map_hi ? MAP_BASE_HI : MAP_BASE_LO) + {6'd0, bg_y[7:3], map_col};

    // signed mode sign-extends the tile number around 9000h
    assign tile_off  = cfg.tile_unsigned ? {4'd0, vram_data, 4'd0}
                                         : {{4{vram_data[7]}}, vram_data, 4'd0};
    assign tile_addr = (cfg.tile_unsigned ? TILE_BASE_UNSIGNED : TILE_BASE_SIGNED)
                     + tile_off + {12'd0, bg_y[2:0], 1'b0};

    assign data_ok = (lat_cnt == CW'(VRAM_LATENCY));
    assign row.lo  = lo_q;
    assign row.hi  = hi_q;

    always_ff @(posedge clk) begin
        if (rst || pos.mode != draw) begin
            state     <= fetch_idle;
            tile_col  <= 5'd0;
            lat_cnt   <= '0;
            vram_rd   <= 1'b0;
            row_valid <= 1'b0;
        end else begin
            vram_rd   <= 1'b0;
            row_valid <= 1'b0;
            if (!data_ok) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
            case (state)
                fetch_idle: begin
                    if (tile_col < 5'(TILES)) begin
                        vram_rd   <= 1'b1;
                        vram_addr <= map_addr;
                        lat_cnt   <= '0;
                        state     <= fetch_map;
                    end
                end
                fetch_map: begin
                    if (data_ok) begin
                        vram_rd   <= 1'b1;   // vram_data is the tile number here
                        vram_addr <= tile_addr;
                        lat_cnt   <= '0;
                        state     <= fetch_lo;
                    end
                end
                fetch_lo: begin
                    if (data_ok) begin
                        lo_q      <= cfg.bg_on ? vram_data : 8'd0;
                        vram_rd   <= 1'b1;
                        vram_addr <= vram_addr + 16'd1;   // hi byte follows lo
                        lat_cnt   <= '0;
                        state     <= fetch_hi;
                    end
                end
                fetch_hi: begin
                    if (data_ok) begin
                        hi_q  <= cfg.bg_on ? vram_data : 8'd0;
                        state <= fetch_hold;
                    end
                end
                fetch_hold: begin
                    if (row_free) begin
                        row_valid <= 1'b1;
                        tile_col  <= tile_col + 5'd1;
                        state     <= fetch_idle;
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/pixel_shifter.sv
// one-row buffer, pixel shift registers and per-line pixel counter
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter (
    input  logic                clk,
    input  logic                rst,
    input  ppu_pkg::tile_row_t  row,
    input  logic                row_valid,
    output logic                row_free,
    output logic                line_done,
    output logic [1:0]          px,
    output logic                px_valid
);
    import ppu_pkg::*;

    tile_row_t  buf_row;
    logic       buf_full;
    logic [7:0] sr_lo;
    logic [7:0] sr_hi;
    logic [3:0] sr_cnt;    // pixels left in the shift registers
    logic [7:0] px_cnt;
    logic       load_sr;

    // refill while the last pixel goes out so tiles run back to back
    assign load_sr  = buf_full && (sr_cnt <= 4'd1);
    assign row_free = !buf_full;
    assign px_valid = (sr_cnt != 4'd0);
    assign px       = {sr_hi[7], sr_lo[7]};

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_full  <= 1'b0;
            sr_cnt    <= 4'd0;
            px_cnt    <= 8'd0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (row_valid) begin
                buf_full <= 1'b1;
            end else if (load_sr) begin
                buf_full <= 1'b0;
            end
            if (load_sr) begin
                sr_cnt <= 4'd8;
            end else if (px_valid) begin
                sr_cnt <= sr_cnt - 4'd1;
            end
            if (px_valid) begin
                if (px_cnt == 8'(PIXELS_PER_LINE - 1)) begin
                    px_cnt    <= 8'd0;
                    line_done <= 1'b1;
                end else begin
                    px_cnt <= px_cnt + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid) begin
            buf_row <= row;
        end
        if (load_sr) begin
            sr_lo <= buf_row.lo;
            sr_hi <= buf_row.hi;
        end else if (px_valid) begin
            sr_lo <= {sr_lo[6:0], 1'b0};   // msb first
            sr_hi <= {sr_hi[6:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: rtl/ppu_top.sv
// ppu top level chaining register file, line timer, background fetcher and pixel shifter
`timescale 1ns/1ps
`default_nettype none

module ppu_top #(
    parameter int VRAM_LATENCY = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  ppu_pkg::cpu_bus_t  bus,
    output logic [7:0]         rdata,
    output logic               vram_rd,
    output logic [15:0]        vram_addr,
    input  logic [7:0]         vram_data,
    output logic [1:0]         px,
    output logic               px_valid,
    output logic               irq_vblank,
    output logic               irq_stat
);
    import ppu_pkg::*;

    ppu_cfg_t  cfg;
    line_pos_t pos;
    tile_row_t row;
    logic      row_valid;
    logic      row_free;
    logic      line_done;

    ppu_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus),
        .pos        (pos),
        .rdata      (rdata),
        .cfg        (cfg),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    line_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .line_done (line_done),
        .pos       (pos)
    );

    bg_fetcher #(
        .VRAM_LATENCY (VRAM_LATENCY)
    ) u_fetcher (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .pos       (pos),
        .row_free  (row_free),
        .vram_data (vram_data),
        .vram_rd   (vram_rd),
        .vram_addr (vram_addr),
        .row       (row),
        .row_valid (row_valid)
    );

    pixel_shifter u_shifter (
        .clk       (clk),
        .rst       (rst),
        .row       (row),
        .row_valid (row_valid),
        .row_free  (row_free),
        .line_done (line_done),
        .px        (px),
        .px_valid  (px_valid)
    );

endmodule

`default_nettype wire

// File: verif/ppu_model.svh
// testbench vram array, lcg random generator, vram fill and reference background pixel
`ifndef PPU_MODEL_SVH
`define PPU_MODEL_SVH

logic [7:0]  vram_mem [0:65535];
logic [31:0] lcg_state;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = lcg_next();
    return r[23:16];   // upper bits have the longer period
endfunction

task automatic fill_vram();
    int a;
    for (a = 0; a < 65536; a++) begin
        vram_mem[a] = rand_byte();
    end
endtask

// colour index of screen pixel (x, y) for coarse scroll
function automatic logic [1:0] ref_pixel(input int x, input int y, input logic [7:0] scy,
                                         input logic [7:0] scx, input logic map_hi,
                                         input logic tile_unsigned);
    int         row_y;
    int         col;
    int         map_a;
    int         tn;
    int         tile_a;
    int         b;
    logic [7:0] lo;
    logic [7:0] hi;
    row_y  = (y + scy) % 256;
    col    = (x / 8 + scx / 8) % 32;
    map_a  = (map_hi ? 16'h9C00 : 16'h9800) + (row_y / 8) * 32 + col;
    tn     = vram_mem[map_a];
    if (!tile_unsigned && tn >= 128) begin
        tn = tn - 256;   // signed tile number
    end
    tile_a = (tile_unsigned ? 16'h8000 : 16'h9000) + tn * 16 + (row_y % 8) * 2;
    lo     = vram_mem[tile_a];
    hi     = vram_mem[tile_a + 1];
    b      = 7 - (x % 8);  // leftmost pixel in bit 7
    return {hi[b], lo[b]};
endfunction

`endif

// File: verif/tb_ppu.sv
// testbench for the background ppu with vram responder, bus tasks, pixel monitor and tests
`timescale 1ns/1ps
`default_nettype none

module tb_ppu;
    import ppu_pkg::*;

    localparam int LATENCY      = 2;
    localparam int FRAME_CYCLES = 154 * 456;

    logic       clk = 1'b0;
    logic       rst;
    cpu_bus_t   bus;
    logic [7:0] rdata;
    logic       vram_rd;
    logic [15:0] vram_addr;
    logic [7:0] vram_data = 8'h00;
    logic [1:0] px;
    logic       px_valid;
    logic       irq_vblank;
    logic       irq_stat;

    `include "ppu_model.svh"

    int         cyc = 0;
    int         err_cnt = 0;
    int         test_base = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         rsp_cnt = 0;
    logic [15:0] rsp_addr;
    logic       mon_on = 1'b0;   // pixel monitor armed for one frame
    int         mon_cyc;
    int         mon_line;
    int         late_px;
    int         line_cnt [0:143];
    logic [7:0] mon_lcdc;
    logic [7:0] mon_scy;
    logic [7:0] mon_scx;
    logic [1:0] exp_px;

    ppu_top #(.VRAM_LATENCY(LATENCY)) DUT (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus),
        .rdata      (rdata),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .px         (px),
        .px_valid   (px_valid),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // vram answers LATENCY cycles after the read pulse
    always @(posedge clk) begin
        #1;
        if (rsp_cnt == 1) begin
            vram_data = vram_mem[rsp_addr];
        end
        if (rsp_cnt != 0) begin
            rsp_cnt = rsp_cnt - 1;
        end
        if (vram_rd) begin
            rsp_addr = vram_addr;
            rsp_cnt  = LATENCY;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // line position comes from the cycle count since the frame started
    always @(negedge clk) begin
        if (mon_on) begin
            mon_line = mon_cyc / 456;
            if (px_valid) begin
                if (mon_line >= 144) begin
                    late_px++;
                end else begin
                    exp_px = mon_lcdc[0] ? ref_pixel(line_cnt[mon_line], mon_line, mon_scy,
                                                     mon_scx, mon_lcdc[3], mon_lcdc[4]) : 2'b00;
                    if (line_cnt[mon_line] < 160) begin
                        check_eq("px", px, exp_px);
                    end
                    line_cnt[mon_line]++;
                end
            end
            mon_cyc++;
        end
    end

    task tick();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        tick();
        bus = '{addr: a, wr: 1'b1, rd: 1'b0, wdata: d};
        tick();
        bus = '0;   // write has landed
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        tick();
        bus = '{addr: a, wr: 1'b0, rd: 1'b1, wdata: 8'h00};
        #1;
        d = rdata;
    endtask

    task automatic wait_irq(input bit use_stat, input logic level, input int limit,
                            input string what);
        int n;
        n = 0;
        while (((use_stat ? irq_stat : irq_vblank) !== level) && n < limit) begin
            tick();
            n++;
        end
        assert ((use_stat ? irq_stat : irq_vblank) === level)
        else begin
            $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, limit);
            err_cnt++;
        end
    endtask

    task start_test();
        test_base = err_cnt;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt != test_base) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_cnt - test_base);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic register_access();
        logic [7:0] v [0:3];
        logic [7:0] d;
        int         i;
        start_test();
        v[0] = rand_byte() & 8'h7F;   // display stays off
        v[1] = rand_byte();
        v[2] = rand_byte();
        v[3] = rand_byte();
        bus_write(ADDR_LCDC, v[0]);
        bus_write(ADDR_SCY, v[1]);
        bus_write(ADDR_SCX, v[2]);
        bus_write(ADDR_LYC, v[3]);
        bus_read(ADDR_LCDC, d);
        check_eq("LCDC", d, v[0]);
        bus_read(ADDR_SCY, d);
        check_eq("SCY", d, v[1]);
        bus_read(ADDR_SCX, d);
        check_eq("SCX", d, v[2]);
        bus_read(ADDR_LYC, d);
        check_eq("LYC", d, v[3]);
        bus_read(ADDR_STAT, d);
        check_eq("STAT[7]", d[7], 1);
        bus_read(ADDR_LY, d);
        check_eq("LY", d, 0);
        for (i = 16'hFF46; i <= 16'hFF4B; i++) begin
            bus_read(i[15:0], d);
            check_eq("rdata unmapped", d, 8'hFF);
        end
        bus_read(16'hFF00, d);
        check_eq("rdata FF00", d, 8'hFF);
        end_test("register access");
    endtask

    task automatic frame_timing();
        logic [7:0] d;
        int         t0;
        start_test();
        bus_write(ADDR_LCDC, 8'h91);
        wait_irq(0, 1, 2 * FRAME_CYCLES, "first rise of irq_vblank");
        t0 = cyc;
        bus_read(ADDR_LY, d);
        check_eq("LY", d, 144);
        bus_read(ADDR_STAT, d);
        check_eq("STAT[1:0]", d[1:0], 1);
        wait_irq(0, 0, FRAME_CYCLES, "end of v-blank");
        wait_irq(0, 1, FRAME_CYCLES, "second rise of irq_vblank");
        check_eq("irq_vblank period", cyc - t0, FRAME_CYCLES);
        end_test("frame timing");
    endtask

    task automatic coincidence_irq();
        logic [7:0] d;
        logic [7:0] lyc;
        start_test();
        bus_write(ADDR_STAT, 8'h00);
        lyc = rand_byte() % 144;
        bus_write(ADDR_LYC, lyc);
        bus_write(ADDR_STAT, 8'h40);
        wait_irq(1, 0, 2 * FRAME_CYCLES, "irq_stat going low before line LYC");
        wait_irq(1, 1, 2 * FRAME_CYCLES, "irq_stat rise on LY equal to LYC");
        bus_read(ADDR_LY, d);
        check_eq("LY", d, lyc);
        bus_read(ADDR_STAT, d);
        check_eq("STAT[2]", d[2], 1);
        bus_write(ADDR_STAT, 8'h08);   // h-blank source only
        wait_irq(1, 0, 2 * FRAME_CYCLES, "irq_stat going low before h-blank");
        wait_irq(1, 1, 2 * FRAME_CYCLES, "irq_stat rise in h-blank");
        bus_read(ADDR_STAT, d);
        check_eq("STAT[1:0]", d[1:0], 0);
        bus_write(ADDR_STAT, 8'h00);
        end_test("coincidence interrupt");
    endtask

    // config is written in v-blank, then the next full frame is monitored
    task automatic check_frame(input logic [7:0] lcdc_v);
        int l;
        mon_scy  = rand_byte();
        mon_scx  = rand_byte();
        mon_lcdc = lcdc_v;
        wait_irq(0, 0, 2 * FRAME_CYCLES, "irq_vblank low before the frame");
        wait_irq(0, 1, 2 * FRAME_CYCLES, "irq_vblank before the frame");
        bus_write(ADDR_SCY, mon_scy);
        bus_write(ADDR_SCX, mon_scx);
        bus_write(ADDR_LCDC, lcdc_v);
        wait_irq(0, 0, FRAME_CYCLES, "start of the checked frame");
        for (l = 0; l < 144; l++) begin
            line_cnt[l] = 0;
        end
        late_px = 0;
        mon_cyc = 0;
        mon_on  = 1'b1;
        wait_irq(0, 1, FRAME_CYCLES, "v-blank of the checked frame");
        wait_irq(0, 0, FRAME_CYCLES, "end of v-blank after the checked frame");
        mon_on = 1'b0;
        for (l = 0; l < 144; l++) begin
            check_eq("px_valid count per line", line_cnt[l], 160);
        end
        check_eq("px_valid count in v-blank", late_px, 0);
    endtask

    task unsigned_pixels();
        start_test();
        check_frame(8'h91);   // map 0, unsigned tiles
        end_test("unsigned pixels");
    endtask

    task signed_pixels();
        start_test();
        check_frame(8'h89);   // map 1, signed tiles
        check_frame(8'h88);   // background off
        end_test("signed map");
    endtask

    initial begin
        bus       = '0;
        rst       = 1'b1;
        lcg_state = 32'he1a1;
        fill_vram();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        register_access();
        frame_timing();
        coincidence_irq();
        unsigned_pixels();
        signed_pixels();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verif
rtl/ppu_pkg.sv
rtl/ppu_regs.sv
rtl/line_timer.sv
rtl/bg_fetcher.sv
rtl/pixel_shifter.sv
rtl/ppu_top.sv
verif/tb_ppu.sv

// File: Bender.yml
package:
  name: ppu_bg

sources:
  - rtl/ppu_pkg.sv
  - rtl/ppu_regs.sv
  - rtl/line_timer.sv
  - rtl/bg_fetcher.sv
  - rtl/pixel_shifter.sv
  - rtl/ppu_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_ppu.sv
